/* hdl/stack_cpu_pkg.sv */
package stack_cpu_pkg;

    localparam int word_width = 32;
    localparam int addr_width = 24;   // flash byte address
    localparam int byte_width = 8;

    // 8 entries by default
    localparam int stack_depth_log2_default = 3;

    // byte code encodings, wasm subset plus a few forth words
    typedef enum logic [7:0] {
        op_push  = 8'h01,   // followed by imm32
        op_add   = 8'h02,
        op_sub   = 8'h03,
        op_drop  = 8'h05,
        op_print = 8'h08,   // pops, sends low byte
        op_eq    = 8'h09,
        op_lt_s  = 8'h0a,
        op_lt_u  = 8'h0c,
        op_br_if = 8'h0e,   // followed by target address
        op_jump  = 8'h0f,   // followed by target address
        op_dup   = 8'h12,
        op_swap  = 8'h13,
        op_over  = 8'h14,
        op_and   = 8'h16,
        op_or    = 8'h17,
        op_xor   = 8'h18,
        op_not   = 8'h19,
        op_eqz   = 8'h35,
        op_halt  = 8'hff
    } opcode_t;

    // data stack commands, applied on the next edge
    typedef enum logic [2:0] {
        stk_hold,
        stk_push,      // write above top, sp+1
        stk_pop,       // sp-1
        stk_set_top,   // overwrite top
        stk_reduce,    // write into second, sp-1
        stk_swap,
        stk_over       // push copy of second
    } stack_cmd_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_not,
        alu_eq,
        alu_lt_s,
        alu_lt_u,
        alu_eqz
    } alu_op_t;

    // opcodes followed by a 4-byte little-endian immediate
    function automatic logic has_immediate(opcode_t op);
        return op inside {op_push, op_br_if, op_jump};
    endfunction

endpackage

/* hdl/stack_alu.sv */
module stack_alu (
    input  stack_cpu_pkg::alu_op_t              alu_op,
    input  logic [stack_cpu_pkg::word_width-1:0] top,
    input  logic [stack_cpu_pkg::word_width-1:0] second,
    output logic [stack_cpu_pkg::word_width-1:0] result
);

    logic is_eq;
    logic is_lt_s;
    logic is_lt_u;

    // second is the left operand, as pushed first
    assign is_eq   = (second == top);
    assign is_lt_s = ($signed(second) < $signed(top));
    assign is_lt_u = (second < top);

    always_comb begin
        result = '0;
        case (alu_op)
            stack_cpu_pkg::alu_add:  result = second + top;
            stack_cpu_pkg::alu_sub:  result = second - top;
            stack_cpu_pkg::alu_and:  result = second & top;
            stack_cpu_pkg::alu_or:   result = second | top;
            stack_cpu_pkg::alu_xor:  result = second ^ top;
            stack_cpu_pkg::alu_not:  result = ~top;   // unary
            stack_cpu_pkg::alu_eq:   result[0] = is_eq;
            stack_cpu_pkg::alu_lt_s: result[0] = is_lt_s;
            stack_cpu_pkg::alu_lt_u: result[0] = is_lt_u;
            stack_cpu_pkg::alu_eqz:  result[0] = (top == '0);
            default: ;
        endcase
    end

endmodule

/* hdl/data_stack.sv */
module data_stack #(
    parameter int stack_depth_log2 = stack_cpu_pkg::stack_depth_log2_default
) (
    input  logic                                clk,
    input  logic                                reset,
    input  stack_cpu_pkg::stack_cmd_t           stack_cmd,
    input  logic [stack_cpu_pkg::word_width-1:0] push_value,
    output logic [stack_cpu_pkg::word_width-1:0] top,
    output logic [stack_cpu_pkg::word_width-1:0] second
);

    localparam int entries = 2 ** stack_depth_log2;

    logic [stack_cpu_pkg::word_width-1:0] mem [entries];
    logic [stack_depth_log2-1:0]          sp;        // next free slot, wrapping
    logic [stack_depth_log2-1:0]          top_idx;
    logic [stack_depth_log2-1:0]          sec_idx;

    assign top_idx = sp - 1'b1;
    assign sec_idx = sp - 2'd2;
    assign top     = mem[top_idx];
    assign second  = mem[sec_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= '0;
        end else begin
            case (stack_cmd)
                stack_cpu_pkg::stk_push,
                stack_cpu_pkg::stk_over:   sp <= sp + 1'b1;
                stack_cpu_pkg::stk_pop,
                stack_cpu_pkg::stk_reduce: sp <= sp - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (stack_cmd)
            stack_cpu_pkg::stk_push:    mem[sp] <= push_value;
            stack_cpu_pkg::stk_over:    mem[sp] <= second;
            stack_cpu_pkg::stk_set_top: mem[top_idx] <= push_value;
            stack_cpu_pkg::stk_reduce:  mem[sec_idx] <= push_value;
            stack_cpu_pkg::stk_swap: begin
                mem[top_idx] <= second;   // both in one edge
                mem[sec_idx] <= top;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/fetch_unit.sv */
module fetch_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                fetch_start,
    input  logic                                pc_load,
    input  logic [stack_cpu_pkg::addr_width-1:0] pc_target,
    output logic [stack_cpu_pkg::addr_width-1:0] flash_addr,
    output logic                                flash_enable,
    input  logic [stack_cpu_pkg::byte_width-1:0] flash_data,
    input  logic                                flash_ready,
    output logic                                fetch_done,
    output stack_cpu_pkg::opcode_t              opcode,
    output logic [stack_cpu_pkg::word_width-1:0] imm
);

    typedef enum logic [1:0] {
        idle,
        wait_low,    // flash acknowledges by dropping ready
        wait_high    // byte valid once ready returns
    } fetch_state_t;

    fetch_state_t                         state;
    logic [stack_cpu_pkg::addr_width-1:0] pc;
    logic [stack_cpu_pkg::addr_width-1:0] read_addr;
    logic                                 imm_pending;   // immediate bytes still to come
    logic [1:0]                           byte_cnt;
    stack_cpu_pkg::opcode_t               new_opcode;

    // a redirect wins over the sequential pc
    assign read_addr  = pc_load ? pc_target : pc;
    assign new_opcode = stack_cpu_pkg::opcode_t'(flash_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            pc           <= '0;
            flash_addr   <= '0;
            flash_enable <= 1'b0;
            fetch_done   <= 1'b0;
            imm_pending  <= 1'b0;
            byte_cnt     <= '0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                idle: begin
                    if (fetch_start || imm_pending) begin
                        flash_addr   <= read_addr;
                        pc           <= read_addr;
                        flash_enable <= 1'b1;
                        state        <= wait_low;
                    end
                end

                wait_low: begin
                    if (!flash_ready) begin
                        state <= wait_high;
                    end
                end

                wait_high: begin
                    if (flash_ready) begin
                        flash_enable <= 1'b0;   // one byte per enable period
                        pc           <= pc + 1'b1;
                        state        <= idle;
                        if (!imm_pending) begin
                            opcode   <= new_opcode;
                            byte_cnt <= '0;
                            if (stack_cpu_pkg::has_immediate(new_opcode)) begin
                                imm_pending <= 1'b1;
                            end else begin
                                fetch_done <= 1'b1;
                            end
                        end else begin
                            // lowest byte arrives first
                            imm[byte_cnt*stack_cpu_pkg::byte_width +: stack_cpu_pkg::byte_width]
                                <= flash_data;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (byte_cnt == 2'd3) begin
                                imm_pending <= 1'b0;
                                fetch_done  <= 1'b1;
                            end
                        end
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

/* hdl/exec_control.sv */
module exec_control (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                fetch_done,
    input  stack_cpu_pkg::opcode_t              opcode,
    input  logic [stack_cpu_pkg::word_width-1:0] imm,
    input  logic [stack_cpu_pkg::word_width-1:0] top,
    input  logic [stack_cpu_pkg::word_width-1:0] alu_result,
    output logic                                fetch_start,
    output logic                                pc_load,
    output logic [stack_cpu_pkg::addr_width-1:0] pc_target,
    output stack_cpu_pkg::stack_cmd_t           stack_cmd,
    output logic [stack_cpu_pkg::word_width-1:0] push_value,
    output stack_cpu_pkg::alu_op_t              alu_op,
    output logic [stack_cpu_pkg::byte_width-1:0] uart_data,
    output logic                                uart_send,
    input  logic                                uart_busy,
    output logic                                halted
);

    typedef enum logic [1:0] {
        fetching,
        execute,
        uart_wait,
        halt
    } state_t;

    state_t state;
    logic   kick;        // first fetch request after reset
    logic   exec_next;   // single-cycle instruction retires
    logic   uart_done;

    assign exec_next = (state == execute) && (opcode != stack_cpu_pkg::op_print)
                       && (opcode != stack_cpu_pkg::op_halt);
    assign uart_done   = (state == uart_wait) && !uart_busy && !uart_send;
    assign fetch_start = kick || exec_next || uart_done;
    assign pc_target   = imm[stack_cpu_pkg::addr_width-1:0];

    // decode, only acts in the execute cycle
    always_comb begin
        stack_cmd  = stack_cpu_pkg::stk_hold;
        alu_op     = stack_cpu_pkg::alu_add;
        push_value = alu_result;
        pc_load    = 1'b0;
        if (state == execute) begin
            case (opcode)
                stack_cpu_pkg::op_push: begin
                    stack_cmd  = stack_cpu_pkg::stk_push;
                    push_value = imm;
                end
                stack_cpu_pkg::op_dup: begin
                    stack_cmd  = stack_cpu_pkg::stk_push;
                    push_value = top;
                end
                stack_cpu_pkg::op_add: stack_cmd = stack_cpu_pkg::stk_reduce;
                stack_cpu_pkg::op_sub: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_sub;
                end
                stack_cpu_pkg::op_and: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_and;
                end
                stack_cpu_pkg::op_or: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_or;
                end
                stack_cpu_pkg::op_xor: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_xor;
                end
                stack_cpu_pkg::op_eq: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_eq;
                end
                stack_cpu_pkg::op_lt_s: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_lt_s;
                end
                stack_cpu_pkg::op_lt_u: begin
                    stack_cmd = stack_cpu_pkg::stk_reduce;
                    alu_op    = stack_cpu_pkg::alu_lt_u;
                end
                stack_cpu_pkg::op_not: begin
                    stack_cmd = stack_cpu_pkg::stk_set_top;
                    alu_op    = stack_cpu_pkg::alu_not;
                end
                stack_cpu_pkg::op_eqz: begin
                    stack_cmd = stack_cpu_pkg::stk_set_top;
                    alu_op    = stack_cpu_pkg::alu_eqz;
                end
                stack_cpu_pkg::op_drop:  stack_cmd = stack_cpu_pkg::stk_pop;
                stack_cpu_pkg::op_print: stack_cmd = stack_cpu_pkg::stk_pop;
                stack_cpu_pkg::op_swap:  stack_cmd = stack_cpu_pkg::stk_swap;
                stack_cpu_pkg::op_over:  stack_cmd = stack_cpu_pkg::stk_over;
                stack_cpu_pkg::op_br_if: begin
                    stack_cmd = stack_cpu_pkg::stk_pop;   // condition is consumed
                    pc_load   = (top != '0);
                end
                stack_cpu_pkg::op_jump: pc_load = 1'b1;
                default: ;   // unknown opcodes fall through as no-ops
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fetching;
            kick      <= 1'b1;
            uart_send <= 1'b0;
            halted    <= 1'b0;
        end else begin
            kick <= 1'b0;
            case (state)
                fetching: if (fetch_done) state <= execute;
                execute: begin
                    if (opcode == stack_cpu_pkg::op_print) begin
                        uart_data <= top[stack_cpu_pkg::byte_width-1:0];
                        uart_send <= 1'b1;
                        state     <= uart_wait;
                    end else if (opcode == stack_cpu_pkg::op_halt) begin
                        halted <= 1'b1;
                        state  <= halt;
                    end else begin
                        state <= fetching;
                    end
                end
                uart_wait: begin
                    if (uart_send && uart_busy) uart_send <= 1'b0;   // transmitter took it
                    if (uart_done) state <= fetching;
                end
                halt: state <= halt;   // only reset leaves
                default: state <= fetching;
            endcase
        end
    end

endmodule

/* hdl/stack_cpu.sv */
module stack_cpu #(
    parameter int stack_depth_log2 = stack_cpu_pkg::stack_depth_log2_default
) (
    input  logic                                clk,
    input  logic                                reset,
    output logic [stack_cpu_pkg::addr_width-1:0] flash_addr,
    output logic                                flash_enable,
    input  logic [stack_cpu_pkg::byte_width-1:0] flash_data,
    input  logic                                flash_ready,
    output logic [stack_cpu_pkg::byte_width-1:0] uart_data,
    output logic                                uart_send,
    input  logic                                uart_busy,
    output logic                                halted
);

    logic                                 fetch_start;
    logic                                 fetch_done;
    logic                                 pc_load;
    logic [stack_cpu_pkg::addr_width-1:0] pc_target;
    stack_cpu_pkg::opcode_t               opcode;
    logic [stack_cpu_pkg::word_width-1:0] imm;

    stack_cpu_pkg::stack_cmd_t            stack_cmd;
    logic [stack_cpu_pkg::word_width-1:0] push_value;
    logic [stack_cpu_pkg::word_width-1:0] top;
    logic [stack_cpu_pkg::word_width-1:0] second;
    stack_cpu_pkg::alu_op_t               alu_op;
    logic [stack_cpu_pkg::word_width-1:0] alu_result;

    fetch_unit u_fetch (
        .clk          (clk),
        .reset        (reset),
        .fetch_start  (fetch_start),
        .pc_load      (pc_load),
        .pc_target    (pc_target),
        .flash_addr   (flash_addr),
        .flash_enable (flash_enable),
        .flash_data   (flash_data),
        .flash_ready  (flash_ready),
        .fetch_done   (fetch_done),
        .opcode       (opcode),
        .imm          (imm)
    );

    exec_control u_exec (
        .clk         (clk),
        .reset       (reset),
        .fetch_done  (fetch_done),
        .opcode      (opcode),
        .imm         (imm),
        .top         (top),
        .alu_result  (alu_result),
        .fetch_start (fetch_start),
        .pc_load     (pc_load),
        .pc_target   (pc_target),
        .stack_cmd   (stack_cmd),
        .push_value  (push_value),
        .alu_op      (alu_op),
        .uart_data   (uart_data),
        .uart_send   (uart_send),
        .uart_busy   (uart_busy),
        .halted      (halted)
    );

    data_stack #(
        .stack_depth_log2 (stack_depth_log2)
    ) u_stack (
        .clk        (clk),
        .reset      (reset),
        .stack_cmd  (stack_cmd),
        .push_value (push_value),
        .top        (top),
        .second     (second)
    );

    stack_alu u_alu (
        .alu_op (alu_op),
        .top    (top),
        .second (second),
        .result (alu_result)
    );

endmodule

/* testbench/stack_cpu_tests.svh */
// pushes s and t, applies op and prints the result
task automatic binary_case(input stack_cpu_pkg::opcode_t op, input logic [31:0] s,
                           input logic [31:0] t, input logic [31:0] result);
    emit(stack_cpu_pkg::op_push, s);
    emit(stack_cpu_pkg::op_push, t);
    emit(op, 0);
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(result);
endtask

task automatic unary_case(input stack_cpu_pkg::opcode_t op, input logic [31:0] t,
                          input logic [31:0] result);
    emit(stack_cpu_pkg::op_push, t);
    emit(op, 0);
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(result);
endtask

// emits one op and applies it to the queue model
task automatic stack_step(input stack_cpu_pkg::opcode_t op, input logic [31:0] value);
    logic [31:0] t;
    logic [31:0] s;
    emit(op, value);
    case (op)
        stack_cpu_pkg::op_push: model.push_back(value);
        stack_cpu_pkg::op_dup:  model.push_back(model[$]);
        stack_cpu_pkg::op_over: model.push_back(model[model.size() - 2]);
        stack_cpu_pkg::op_drop: void'(model.pop_back());
        stack_cpu_pkg::op_swap: begin
            t = model.pop_back();
            s = model.pop_back();
            model.push_back(t);
            model.push_back(s);
        end
        stack_cpu_pkg::op_print: begin
            t = model.pop_back();
            expect_byte(t);
        end
        default: ;
    endcase
endtask

task automatic arithmetic_ops();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    begin_program();
    binary_case(stack_cpu_pkg::op_add, a, b, a + b);
    binary_case(stack_cpu_pkg::op_sub, a, b, a - b);
    emit(stack_cpu_pkg::op_halt, 0);
    run_program();
endtask

task automatic logic_and_compare();
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] neg;
    logic [31:0] two;
    x = lcg_next();
    y = lcg_next();
    neg = 32'hffff_fffd;   // -3 reads as huge when unsigned
    two = 32'd2;
    begin_program();
    binary_case(stack_cpu_pkg::op_and, x, y, x & y);
    binary_case(stack_cpu_pkg::op_or, x, y, x | y);
    binary_case(stack_cpu_pkg::op_xor, x, y, x ^ y);
    unary_case(stack_cpu_pkg::op_not, x, ~x);
    binary_case(stack_cpu_pkg::op_eq, x, x, 32'd1);
    binary_case(stack_cpu_pkg::op_eq, x, y, x == y);
    binary_case(stack_cpu_pkg::op_lt_s, neg, two, 32'd1);
    binary_case(stack_cpu_pkg::op_lt_s, two, neg, 32'd0);
    binary_case(stack_cpu_pkg::op_lt_u, neg, two, 32'd0);
    binary_case(stack_cpu_pkg::op_lt_u, two, neg, 32'd1);
    unary_case(stack_cpu_pkg::op_eqz, 32'd0, 32'd1);
    unary_case(stack_cpu_pkg::op_eqz, y, y == 32'd0);
    emit(stack_cpu_pkg::op_halt, 0);
    run_program();
endtask

task automatic stack_shuffle();
    begin_program();
    stack_step(stack_cpu_pkg::op_push, lcg_next());
    stack_step(stack_cpu_pkg::op_push, lcg_next());
    stack_step(stack_cpu_pkg::op_push, lcg_next());
    stack_step(stack_cpu_pkg::op_swap, 0);
    stack_step(stack_cpu_pkg::op_over, 0);
    stack_step(stack_cpu_pkg::op_dup, 0);
    stack_step(stack_cpu_pkg::op_drop, 0);
    stack_step(stack_cpu_pkg::op_swap, 0);
    stack_step(stack_cpu_pkg::op_over, 0);
    while (model.size() != 0) stack_step(stack_cpu_pkg::op_print, 0);
    emit(stack_cpu_pkg::op_halt, 0);
    run_program();
endtask

task automatic branch_flow();
    int jump_at;
    int taken_at;
    int fall_at;
    begin_program();
    emit(stack_cpu_pkg::op_jump, 0);
    jump_at = prog_len - 5;
    emit(stack_cpu_pkg::op_push, 32'haa);   // skipped by the jump
    emit(stack_cpu_pkg::op_print, 0);
    patch_imm(jump_at, prog_len);
    emit(stack_cpu_pkg::op_push, 32'h11);
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(32'h11);
    emit(stack_cpu_pkg::op_push, 32'd1);
    emit(stack_cpu_pkg::op_br_if, 0);
    taken_at = prog_len - 5;
    emit(stack_cpu_pkg::op_push, 32'hbb);   // skipped as the condition is non-zero
    emit(stack_cpu_pkg::op_print, 0);
    patch_imm(taken_at, prog_len);
    emit(stack_cpu_pkg::op_push, 32'h22);
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(32'h22);
    emit(stack_cpu_pkg::op_push, 32'd0);
    emit(stack_cpu_pkg::op_br_if, 0);
    fall_at = prog_len - 5;
    emit(stack_cpu_pkg::op_push, 32'h33);   // runs because zero falls through
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(32'h33);
    patch_imm(fall_at, prog_len);
    emit(stack_cpu_pkg::op_push, 32'h44);
    emit(stack_cpu_pkg::op_print, 0);
    expect_byte(32'h44);
    emit(stack_cpu_pkg::op_halt, 0);
    run_program();
endtask

task automatic halt_and_restart();
    logic [31:0] c;
    c = lcg_next();
    begin_program();
    emit(stack_cpu_pkg::op_push, c);
    emit(stack_cpu_pkg::op_print, 0);
    emit(stack_cpu_pkg::op_halt, 0);
    expect_byte(c);
    run_program();
    repeat (50) begin
        @(negedge clk);
        check_value("halted", halted, 32'd1);
        check_value("flash_enable", flash_enable, 32'd0);
    end
    // same image again after reset
    grant_cycles();
    apply_reset();
    @(negedge clk);
    check_value("halted", halted, 32'd0);
    while (!flash_enable) @(negedge clk);
    check_value("flash_addr", flash_addr, 32'd0);
    wait_halted();
    compare_prints();
endtask

/* testbench/stack_cpu_tb.sv */
module stack_cpu_tb;

    logic                                 clk;
    logic                                 reset = 1'b1;
    logic [stack_cpu_pkg::addr_width-1:0] flash_addr;
    logic                                 flash_enable;
    logic [stack_cpu_pkg::byte_width-1:0] flash_data = '0;
    logic                                 flash_ready = 1'b1;
    logic [stack_cpu_pkg::byte_width-1:0] uart_data;
    logic                                 uart_send;
    logic                                 uart_busy = 1'b0;
    logic                                 halted;

    logic [7:0]  flash_mem [256];    // program image
    logic [1:0]  flash_phase = '0;
    int          busy_left = 0;
    logic [7:0]  printed [$];        // bytes taken by the uart
    logic [7:0]  expected [$];
    logic [31:0] model [$];          // queue model of the stack with top at the back
    int          prog_len = 0;
    int          errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 200;  // raised for every program run
    logic [31:0] lcg_state = 32'd9;

    stack_cpu #(
        .stack_depth_log2 (stack_cpu_pkg::stack_depth_log2_default)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .flash_addr   (flash_addr),
        .flash_enable (flash_enable),
        .flash_data   (flash_data),
        .flash_ready  (flash_ready),
        .uart_data    (uart_data),
        .uart_send    (uart_send),
        .uart_busy    (uart_busy),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // flash drops ready for a cycle, then returns the byte with ready high
    always @(posedge clk) begin
        if (reset || !flash_enable) begin
            flash_ready <= 1'b1;
            flash_phase <= 2'd0;
        end else if (flash_phase == 2'd0) begin
            flash_ready <= 1'b0;
            flash_phase <= 2'd1;
        end else if (flash_phase == 2'd1) begin
            flash_data  <= flash_mem[flash_addr[7:0]];
            flash_ready <= 1'b1;
            flash_phase <= 2'd2;   // hold until enable drops
        end
    end

    // uart holds busy for 3 cycles per accepted byte
    always @(posedge clk) begin
        if (reset) begin
            uart_busy <= 1'b0;
            busy_left <= 0;
        end else if (busy_left != 0) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) uart_busy <= 1'b0;
        end else if (uart_send && !uart_busy) begin
            uart_busy <= 1'b1;
            busy_left <= 3;
            printed.push_back(uart_data);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run("timeout: the DUT did not reach halt within its cycle budget");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            abort_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // opcode byte, then the immediate lowest byte first
    task automatic emit(input stack_cpu_pkg::opcode_t op, input logic [31:0] value);
        flash_mem[prog_len] = op;
        prog_len++;
        if (stack_cpu_pkg::has_immediate(op)) begin
            for (int i = 0; i < 4; i++) begin
                flash_mem[prog_len] = value[8*i +: 8];
                prog_len++;
            end
        end
    endtask

    task automatic patch_imm(input int at, input logic [31:0] target);
        for (int i = 0; i < 4; i++) begin
            flash_mem[at + 1 + i] = target[8*i +: 8];
        end
    endtask

    task automatic expect_byte(input logic [31:0] word);
        expected.push_back(word[7:0]);   // only the low byte goes out
    endtask

    task automatic begin_program();
        prog_len = 0;
        expected.delete();
        model.delete();
    endtask

    task automatic grant_cycles();
        cycle_limit += 40 * prog_len + 100;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        printed.delete();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_halted();
        while (!halted) @(negedge clk);
    endtask

    task automatic compare_prints();
        check_value("print count", printed.size(), expected.size());
        foreach (expected[i]) begin
            check_value($sformatf("uart_data[%0d]", i), printed[i], expected[i]);
        end
    endtask

    task automatic run_program();
        grant_cycles();
        apply_reset();
        wait_halted();
        compare_prints();
    endtask

    `include "stack_cpu_tests.svh"

    initial begin
        arithmetic_ops();
        logic_and_compare();
        stack_shuffle();
        branch_flow();
        halt_and_restart();
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("some checks failed");
        end
    end

endmodule

/* stack_cpu.f */
+incdir+testbench
hdl/stack_cpu_pkg.sv
hdl/stack_alu.sv
hdl/data_stack.sv
hdl/fetch_unit.sv
hdl/exec_control.sv
hdl/stack_cpu.sv
testbench/stack_cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= stack_cpu_tb
FILELIST  ?= stack_cpu.f
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
